// ==== hdl/dbg_params.svh ====
`ifndef DBG_PARAMS_SVH
`define DBG_PARAMS_SVH

//----------------------------------------------------------------------------
// widths
//----------------------------------------------------------------------------
`define DBG_ADDR_W      15          // debug bus address
`define DBG_DATA_W      32          // data path
`define REG_ADDR_W      5           // regfile index, also debug reg index
`define CAUSE_W         6           // trap cause
`define REGION_W        6           // region code in addr[13:8]

// address fields
`define ADDR_EXT_BIT    14          // set means unmapped (was csr space)
`define ADDR_RGN_HI     13
`define ADDR_RGN_LO     8
`define ADDR_IDX_HI     6
`define ADDR_IDX_LO     2

//----------------------------------------------------------------------------
// register map
//----------------------------------------------------------------------------
`define REGION_DBGA     6'h00       // always accessible
`define REGION_DBGS     6'h20       // halted only
`define REGION_GPR      6'h04       // register file

`define REG_CTRL        5'd0
`define REG_HIT         5'd1
`define REG_IE          5'd2
`define REG_CAUSE       5'd3
`define REG_NPC         5'd0        // dbgs region, jump target on write

// bit positions
`define CTRL_HALT_BIT   16
`define HIT_SLEEP_BIT   16
`define IE_ECALL_BIT    11
`define IE_ELSU_LO_BIT  5
`define IE_ELSU_HI_BIT  7
`define IE_EBRK_BIT     3
`define IE_EILL_BIT     2
`define CAUSE_HI_BIT    31          // cause msb lands here on readback

`define CAUSE_HALT      6'h1F       // debugger requested halt

`endif

// ==== hdl/dbg_pkg.sv ====
package dbg_pkg;

  //--------------------------------------------------------------------------
  // halt controller states
  //--------------------------------------------------------------------------
  typedef enum logic [1:0] {
    RUNNING  = 2'd0,  // core runs freely
    HALT_REQ = 2'd1,  // dbg_req_o up, waiting for ack
    HALTED   = 2'd2   // core stalled, debugger owns it
  } halt_state_e;

  //--------------------------------------------------------------------------
  // read data select, latched in the grant cycle
  //--------------------------------------------------------------------------
  typedef enum logic [1:0] {
    RD_NONE = 2'd0,   // unmapped or refused, returns zero
    RD_GPR  = 2'd1,   // regfile read port
    RD_DBGA = 2'd2,   // ctrl, hit, ie, cause
    RD_DBGS = 2'd3    // npc, ppc
  } rd_sel_e;

  // settings seen by the core
  typedef struct packed {
    logic ecall;  // trap on ecall
    logic elsu;   // trap on load/store fault
    logic ebrk;   // trap on ebreak
    logic eill;   // trap on illegal instr
    logic sste;   // single step enable
  } dbg_settings_t;

endpackage

// ==== hdl/dbg_halt_if.sv ====
`timescale 1ns/1ps
`include "dbg_params.svh"

interface dbg_halt_if;
  import dbg_pkg::*;

  // from register block
  logic                halt_cmd;    // ctrl write, halt bit set
  logic                resume_cmd;  // ctrl write, halt bit clear
  logic                ssth_clear;  // hit write, bit 0 set
  logic                sstep_en;    // sste setting

  // from halt controller
  halt_state_e         state;
  logic [`CAUSE_W-1:0] cause;
  logic                ssth;        // single step hit

  logic                halted;

  // everyone outside the controller only cares about halted
  assign halted = (state == HALTED);

  modport regs_mp (
    output halt_cmd, resume_cmd, ssth_clear, sstep_en,
    input  halted, cause, ssth
  );

  modport ctrl_mp (
    input  halt_cmd, resume_cmd, ssth_clear, sstep_en,
    output state, cause, ssth
  );

  modport decoder_mp (input halted);

endinterface

// ==== hdl/dbg_access_if.sv ====
`timescale 1ns/1ps
`include "dbg_params.svh"

interface dbg_access_if;
  import dbg_pkg::*;

  // write side, valid in the request cycle
  logic                   wr_en;    // one cycle strobe
  rd_sel_e                wr_sel;   // RD_DBGA or RD_DBGS region
  logic [`REG_ADDR_W-1:0] wr_idx;   // addr[6:2]
  logic [`DBG_DATA_W-1:0] wr_data;

  // read side, valid in the rvalid cycle
  rd_sel_e                rd_sel;
  logic [`REG_ADDR_W-1:0] rd_idx;
  logic [`DBG_DATA_W-1:0] rd_data;

  modport decoder_mp (
    output wr_en, wr_sel, wr_idx, wr_data, rd_sel, rd_idx,
    input  rd_data
  );

  modport regs_mp (
    input  wr_en, wr_sel, wr_idx, wr_data, rd_sel, rd_idx,
    output rd_data
  );

endinterface

// ==== hdl/dbg_bus_decoder.sv ====
`timescale 1ns/1ps
`include "dbg_params.svh"

module dbg_bus_decoder (
  input  logic                   clk,
  input  logic                   rst_n,
  // debug bus
  input  logic                   debug_req_i,
  input  logic                   debug_we_i,
  input  logic [`DBG_ADDR_W-1:0] debug_addr_i,
  input  logic [`DBG_DATA_W-1:0] debug_wdata_i,
  output logic                   debug_gnt_o,
  output logic                   debug_rvalid_o,
  output logic [`DBG_DATA_W-1:0] debug_rdata_o,
  // regfile ports
  output logic                   regfile_rreq_o,
  output logic [`REG_ADDR_W-1:0] regfile_raddr_o,
  input  logic [`DBG_DATA_W-1:0] regfile_rdata_i,
  output logic                   regfile_wreq_o,
  output logic [`REG_ADDR_W-1:0] regfile_waddr_o,
  output logic [`DBG_DATA_W-1:0] regfile_wdata_o,
  // jump to new npc
  output logic                   jump_req_o,
  output logic [`DBG_DATA_W-1:0] jump_addr_o,
  dbg_access_if.decoder_mp       acc,
  dbg_halt_if.decoder_mp         hlt
);
  import dbg_pkg::*;

  logic [`REGION_W-1:0]   region;
  logic [`REG_ADDR_W-1:0] idx;
  logic                   hit_dbga, hit_dbgs, hit_gpr;
  logic                   wr_req;

  rd_sel_e                rd_sel_n, rd_sel_q;
  logic                   rreq_n, rreq_q;
  logic                   jump_n, jump_q;
  logic [`REG_ADDR_W-1:0] idx_q;      // latched index
  logic [`DBG_DATA_W-1:0] wdata_q;    // latched data, jump target

  //--------------------------------------------------------------------------
  // address decode
  //--------------------------------------------------------------------------
  assign region   = debug_addr_i[`ADDR_RGN_HI:`ADDR_RGN_LO];
  assign idx      = debug_addr_i[`ADDR_IDX_HI:`ADDR_IDX_LO];
  assign hit_dbga = ~debug_addr_i[`ADDR_EXT_BIT] && (region == `REGION_DBGA);
  assign hit_dbgs = ~debug_addr_i[`ADDR_EXT_BIT] && (region == `REGION_DBGS);
  assign hit_gpr  = ~debug_addr_i[`ADDR_EXT_BIT] && (region == `REGION_GPR);

  assign debug_gnt_o = debug_req_i;   // no back-pressure, unmapped granted too
  assign wr_req      = debug_req_i & debug_we_i;

  // debug reg writes, dbgs only while halted
  assign acc.wr_en   = wr_req & (hit_dbga | (hit_dbgs & hlt.halted));
  assign acc.wr_sel  = hit_dbgs ? RD_DBGS : RD_DBGA;
  assign acc.wr_idx  = idx;
  assign acc.wr_data = debug_wdata_i;

  // gpr write goes out straight from the request
  assign regfile_wreq_o  = wr_req & hit_gpr & hlt.halted;
  assign regfile_waddr_o = idx;
  assign regfile_wdata_o = debug_wdata_i;

  //--------------------------------------------------------------------------
  // next read select and delayed strobes
  //--------------------------------------------------------------------------
  always_comb begin
    rd_sel_n = RD_NONE;
    rreq_n   = 1'b0;
    jump_n   = 1'b0;
    if (debug_req_i) begin
      if (debug_we_i) begin
        jump_n = hit_dbgs & hlt.halted & (idx == `REG_NPC); // dnpc
      end else if (hit_dbga) begin
        rd_sel_n = RD_DBGA;
      end else if (hit_dbgs && hlt.halted) begin
        rd_sel_n = RD_DBGS;
      end else if (hit_gpr && hlt.halted) begin
        rd_sel_n = RD_GPR;
        rreq_n   = 1'b1;                // read port fires next cycle
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      debug_rvalid_o <= 1'b0;
      rd_sel_q       <= RD_NONE;
      rreq_q         <= 1'b0;
      jump_q         <= 1'b0;
    end else begin
      debug_rvalid_o <= debug_gnt_o;  // rvalid one cycle after every grant
      rd_sel_q       <= rd_sel_n;
      rreq_q         <= rreq_n;
      jump_q         <= jump_n;
    end
  end

  // payload, only moves on a request
  always_ff @(posedge clk) begin
    if (debug_req_i) begin
      idx_q   <= idx;
      wdata_q <= debug_wdata_i;
    end
  end

  assign regfile_rreq_o  = rreq_q;
  assign regfile_raddr_o = idx_q;
  assign jump_req_o      = jump_q;
  assign jump_addr_o     = wdata_q;

  assign acc.rd_sel = rd_sel_q;
  assign acc.rd_idx = idx_q;

  //--------------------------------------------------------------------------
  // read data mux, valid with rvalid
  //--------------------------------------------------------------------------
  always_comb begin
    case (rd_sel_q)
      RD_GPR:           debug_rdata_o = regfile_rdata_i;  // core answers comb.
      RD_DBGA, RD_DBGS: debug_rdata_o = acc.rd_data;
      default:          debug_rdata_o = '0;               // refused or unmapped
    endcase
  end

endmodule

// ==== hdl/dbg_regs.sv ====
`timescale 1ns/1ps
`include "dbg_params.svh"

module dbg_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  dbg_access_if.regs_mp          acc,
  dbg_halt_if.regs_mp            hlt,
  input  logic                   sleeping_i,
  input  logic [`DBG_DATA_W-1:0] pc_if_i,     // npc
  input  logic [`DBG_DATA_W-1:0] pc_id_i,     // ppc
  output dbg_pkg::dbg_settings_t settings_o
);
  import dbg_pkg::*;

  dbg_settings_t          settings_q;
  logic                   wr_dbga;
  logic                   wr_ctrl, wr_hit, wr_ie;
  logic [`DBG_DATA_W-1:0] rdata;

  //--------------------------------------------------------------------------
  // write decode
  //--------------------------------------------------------------------------
  assign wr_dbga = acc.wr_en && (acc.wr_sel == RD_DBGA);   // dbgs writes are jumps
  assign wr_ctrl = wr_dbga && (acc.wr_idx == `REG_CTRL);
  assign wr_hit  = wr_dbga && (acc.wr_idx == `REG_HIT);
  assign wr_ie   = wr_dbga && (acc.wr_idx == `REG_IE);

  // halt bit picks the command
  assign hlt.halt_cmd   = wr_ctrl &  acc.wr_data[`CTRL_HALT_BIT];
  assign hlt.resume_cmd = wr_ctrl & ~acc.wr_data[`CTRL_HALT_BIT];
  assign hlt.ssth_clear = wr_hit  &  acc.wr_data[0];
  assign hlt.sstep_en   = settings_q.sste;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      settings_q <= '0;
    end else begin
      if (wr_ctrl) begin
        settings_q.sste <= acc.wr_data[0];
      end
      if (wr_ie) begin
        settings_q.ecall <= acc.wr_data[`IE_ECALL_BIT];
        // both lsu bits collapse into one enable
        settings_q.elsu  <= acc.wr_data[`IE_ELSU_HI_BIT] | acc.wr_data[`IE_ELSU_LO_BIT];
        settings_q.ebrk  <= acc.wr_data[`IE_EBRK_BIT];
        settings_q.eill  <= acc.wr_data[`IE_EILL_BIT];
      end
    end
  end

  assign settings_o = settings_q;

  //--------------------------------------------------------------------------
  // readback, driven in the rvalid cycle
  //--------------------------------------------------------------------------
  always_comb begin
    rdata = '0;
    case (acc.rd_sel)
      RD_DBGA: begin
        case (acc.rd_idx)
          `REG_CTRL: begin
            rdata[`CTRL_HALT_BIT] = hlt.halted;
            rdata[0]              = settings_q.sste;
          end
          `REG_HIT: begin
            rdata[`HIT_SLEEP_BIT] = sleeping_i;
            rdata[0]              = hlt.ssth;
          end
          `REG_IE: begin
            rdata[`IE_ECALL_BIT]   = settings_q.ecall;
            rdata[`IE_ELSU_HI_BIT] = settings_q.elsu;   // mirrored
            rdata[`IE_ELSU_LO_BIT] = settings_q.elsu;
            rdata[`IE_EBRK_BIT]    = settings_q.ebrk;
            rdata[`IE_EILL_BIT]    = settings_q.eill;
          end
          `REG_CAUSE: begin
            rdata[`CAUSE_HI_BIT]  = hlt.cause[`CAUSE_W-1];  // interrupt flag
            rdata[`CAUSE_W-2:0]   = hlt.cause[`CAUSE_W-2:0];
          end
          default: rdata = '0;   // unmapped index
        endcase
      end
      RD_DBGS: rdata = acc.rd_idx[0] ? pc_id_i : pc_if_i;   // ppc : npc
      default: rdata = '0;
    endcase
  end

  assign acc.rd_data = rdata;

endmodule

// ==== hdl/dbg_halt_ctrl.sv ====
`timescale 1ns/1ps
`include "dbg_params.svh"

module dbg_halt_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  dbg_halt_if.ctrl_mp         hlt,
  input  logic                debug_halt_i,
  input  logic                debug_resume_i,
  input  logic                trap_i,
  input  logic [`CAUSE_W-1:0] exc_cause_i,
  input  logic                dbg_ack_i,
  output logic                dbg_req_o,
  output logic                stall_o,
  output logic                debug_halted_o
);
  import dbg_pkg::*;

  halt_state_e         state_q, state_n;
  logic [`CAUSE_W-1:0] cause_q, cause_n;
  logic                ssth_q, ssth_n;
  logic                halt_any, resume_any;

  assign halt_any   = hlt.halt_cmd | debug_halt_i | trap_i;
  assign resume_any = hlt.resume_cmd | debug_resume_i;

  //--------------------------------------------------------------------------
  // halt / resume fsm
  //--------------------------------------------------------------------------
  always_comb begin
    state_n        = state_q;
    cause_n        = cause_q;
    ssth_n         = ssth_q;
    dbg_req_o      = 1'b0;
    stall_o        = 1'b0;
    debug_halted_o = 1'b0;

    case (state_q)
      RUNNING: begin
        ssth_n = 1'b0;                  // hit only lives while halted
        if (halt_any) begin
          dbg_req_o = 1'b1;             // same cycle as the request
          state_n   = HALT_REQ;
          if (trap_i) begin
            cause_n = exc_cause_i;
            ssth_n  = hlt.sstep_en;
          end else begin
            cause_n = `CAUSE_HALT;
          end
        end
      end
      HALT_REQ: begin
        dbg_req_o = 1'b1;               // hold until core acks
        if (dbg_ack_i) state_n = HALTED;
        if (resume_any) state_n = RUNNING;
      end
      HALTED: begin
        stall_o        = ~resume_any;   // drop stall right away on resume
        debug_halted_o = 1'b1;          // halted flag follows one cycle later
        if (resume_any) state_n = RUNNING;
      end
      default: state_n = RUNNING;
    endcase

    if (hlt.ssth_clear) ssth_n = 1'b0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RUNNING;
      cause_q <= `CAUSE_HALT;
      ssth_q  <= 1'b0;
    end else begin
      state_q <= state_n;
      cause_q <= cause_n;
      ssth_q  <= ssth_n;
    end
  end

  assign hlt.state = state_q;
  assign hlt.cause = cause_q;
  assign hlt.ssth  = ssth_q;

endmodule

// ==== hdl/dbg_unit_top.sv ====
`timescale 1ns/1ps
`include "dbg_params.svh"

module dbg_unit_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // debugger bus
  input  logic                   debug_req_i,
  input  logic                   debug_we_i,
  input  logic [`DBG_ADDR_W-1:0] debug_addr_i,
  input  logic [`DBG_DATA_W-1:0] debug_wdata_i,
  output logic                   debug_gnt_o,
  output logic                   debug_rvalid_o,
  output logic [`DBG_DATA_W-1:0] debug_rdata_o,
  // debugger halt / resume
  input  logic                   debug_halt_i,
  input  logic                   debug_resume_i,
  output logic                   debug_halted_o,
  // core side
  output dbg_pkg::dbg_settings_t settings_o,
  input  logic                   trap_i,
  input  logic [`CAUSE_W-1:0]    exc_cause_i,
  output logic                   stall_o,
  output logic                   dbg_req_o,
  input  logic                   dbg_ack_i,
  input  logic                   sleeping_i,
  // regfile
  output logic                   regfile_rreq_o,
  output logic [`REG_ADDR_W-1:0] regfile_raddr_o,
  input  logic [`DBG_DATA_W-1:0] regfile_rdata_i,
  output logic                   regfile_wreq_o,
  output logic [`REG_ADDR_W-1:0] regfile_waddr_o,
  output logic [`DBG_DATA_W-1:0] regfile_wdata_o,
  // pcs and jump
  input  logic [`DBG_DATA_W-1:0] pc_if_i,
  input  logic [`DBG_DATA_W-1:0] pc_id_i,
  output logic                   jump_req_o,
  output logic [`DBG_DATA_W-1:0] jump_addr_o
);

  dbg_access_if acc_if ();
  dbg_halt_if   hlt_if ();

  //--------------------------------------------------------------------------
  // bus side
  //--------------------------------------------------------------------------
  dbg_bus_decoder u_decoder (
    .clk             (clk),
    .rst_n           (rst_n),
    .debug_req_i     (debug_req_i),
    .debug_we_i      (debug_we_i),
    .debug_addr_i    (debug_addr_i),
    .debug_wdata_i   (debug_wdata_i),
    .debug_gnt_o     (debug_gnt_o),
    .debug_rvalid_o  (debug_rvalid_o),
    .debug_rdata_o   (debug_rdata_o),
    .regfile_rreq_o  (regfile_rreq_o),
    .regfile_raddr_o (regfile_raddr_o),
    .regfile_rdata_i (regfile_rdata_i),
    .regfile_wreq_o  (regfile_wreq_o),
    .regfile_waddr_o (regfile_waddr_o),
    .regfile_wdata_o (regfile_wdata_o),
    .jump_req_o      (jump_req_o),
    .jump_addr_o     (jump_addr_o),
    .acc             (acc_if.decoder_mp),
    .hlt             (hlt_if.decoder_mp)
  );

  dbg_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .acc        (acc_if.regs_mp),
    .hlt        (hlt_if.regs_mp),
    .sleeping_i (sleeping_i),
    .pc_if_i    (pc_if_i),
    .pc_id_i    (pc_id_i),
    .settings_o (settings_o)
  );

  // core side
  dbg_halt_ctrl u_halt_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .hlt            (hlt_if.ctrl_mp),
    .debug_halt_i   (debug_halt_i),
    .debug_resume_i (debug_resume_i),
    .trap_i         (trap_i),
    .exc_cause_i    (exc_cause_i),
    .dbg_ack_i      (dbg_ack_i),
    .dbg_req_o      (dbg_req_o),
    .stall_o        (stall_o),
    .debug_halted_o (debug_halted_o)
  );

endmodule

// ==== bench/dbg_unit_sva.sv ====
`timescale 1ns/1ps

module dbg_unit_sva (
  input logic clk,
  input logic rst_n,
  input logic debug_req_i,
  input logic debug_gnt_o,
  input logic debug_rvalid_o,
  input logic regfile_wreq_o,
  input logic stall_o,
  input logic debug_halted_o
);

  // grant is comb from the request, unmapped too
  gnt_eq_req: assert property (@(posedge clk) disable iff (!rst_n)
    debug_gnt_o == debug_req_i)
    else $error("grant differs from request");

  // rvalid exactly one cycle after a grant
  rvalid_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    debug_gnt_o |=> debug_rvalid_o)
    else $error("no rvalid one cycle after grant");

  rvalid_only_after_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    !debug_gnt_o |=> !debug_rvalid_o)
    else $error("rvalid without a grant in the cycle before");

  wreq_when_halted: assert property (@(posedge clk) disable iff (!rst_n)
    regfile_wreq_o |-> debug_halted_o)
    else $error("regfile write while the core runs");

  stall_when_halted: assert property (@(posedge clk) disable iff (!rst_n)
    stall_o |-> debug_halted_o)
    else $error("stall without halted state");

endmodule

bind dbg_unit_top dbg_unit_sva u_sva (
  .clk            (clk),
  .rst_n          (rst_n),
  .debug_req_i    (debug_req_i),
  .debug_gnt_o    (debug_gnt_o),
  .debug_rvalid_o (debug_rvalid_o),
  .regfile_wreq_o (regfile_wreq_o),
  .stall_o        (stall_o),
  .debug_halted_o (debug_halted_o)
);

// ==== bench/dbg_unit_tb.sv ====
`timescale 1ns/1ps
`include "dbg_params.svh"

module dbg_unit_tb;
  import dbg_pkg::*;

  localparam int ACK_DELAY    = 3;     // core ack latency in cycles
  localparam int RVALID_LIMIT = 4;
  localparam int HALT_LIMIT   = 20;
  // tests take about 150 cycles, so this leaves a wide margin
  localparam int MAX_CYCLES   = 2000;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   debug_req_i, debug_we_i;
  logic [`DBG_ADDR_W-1:0] debug_addr_i;
  logic [`DBG_DATA_W-1:0] debug_wdata_i;
  logic                   debug_gnt_o, debug_rvalid_o;
  logic [`DBG_DATA_W-1:0] debug_rdata_o;
  logic                   debug_halt_i, debug_resume_i, debug_halted_o;
  dbg_settings_t          settings_o;
  logic                   trap_i;
  logic [`CAUSE_W-1:0]    exc_cause_i;
  logic                   stall_o, dbg_req_o, dbg_ack_i, sleeping_i;
  logic                   regfile_rreq_o, regfile_wreq_o;
  logic [`REG_ADDR_W-1:0] regfile_raddr_o, regfile_waddr_o;
  logic [`DBG_DATA_W-1:0] regfile_rdata_i, regfile_wdata_o;
  logic [`DBG_DATA_W-1:0] pc_if_i, pc_id_i;
  logic                   jump_req_o;
  logic [`DBG_DATA_W-1:0] jump_addr_o;

  logic [31:0]            gpr_model [0:31];   // core register file
  int                     wr_cnt;             // regfile writes seen
  logic [4:0]             last_waddr;
  logic [31:0]            last_wdata;
  logic [31:0]            lfsr_q = 32'd88604;
  int                     err_cnt = 0;
  int                     check_cnt = 0;

  always #20 clk = ~clk;

  dbg_unit_top DUT (.*);   // port names match one to one

  //--------------------------------------------------------------------------
  // core side model
  //--------------------------------------------------------------------------
  function automatic logic [31:0] fill_word(input logic [4:0] idx);
    return {8'h5A, 3'b000, idx, 8'hC3, 3'b000, idx};   // whole index twice
  endfunction

  assign regfile_rdata_i = gpr_model[regfile_raddr_o];  // comb read port

  initial begin
    for (int i = 0; i < 32; i++) begin
      gpr_model[i] = fill_word(i[4:0]);
    end
    wr_cnt = 0;
    forever begin
      @(negedge clk);
      if (regfile_wreq_o) begin
        gpr_model[regfile_waddr_o] = regfile_wdata_o;
        last_waddr = regfile_waddr_o;
        last_wdata = regfile_wdata_o;
        wr_cnt++;
      end
    end
  end

  // ack a halt request a few cycles later, one cycle wide
  initial begin
    dbg_ack_i = 1'b0;
    forever begin
      @(negedge clk);
      if (dbg_req_o && !dbg_ack_i) begin
        repeat (ACK_DELAY) @(posedge clk);
        #2 dbg_ack_i = 1'b1;
        @(posedge clk);
        #2 dbg_ack_i = 1'b0;
      end
    end
  end

  initial begin
    int cyc;
    cyc = 0;
    while (cyc < MAX_CYCLES) begin
      @(posedge clk);
      cyc++;
    end
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  //--------------------------------------------------------------------------
  // helpers
  //--------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);   // one step per bit
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  function automatic logic [`DBG_ADDR_W-1:0] dbg_addr(input logic [5:0] region,
                                                      input logic [4:0] idx);
    return {1'b0, region, 1'b0, idx, 2'b00};
  endfunction

  // ie readback, lsu pair mirrors the OR of both written bits
  function automatic logic [31:0] ie_readback(input logic [31:0] w);
    logic [31:0] r;
    logic        elsu;
    elsu                 = w[`IE_ELSU_HI_BIT] | w[`IE_ELSU_LO_BIT];
    r                    = '0;
    r[`IE_ECALL_BIT]     = w[`IE_ECALL_BIT];
    r[`IE_ELSU_HI_BIT]   = elsu;
    r[`IE_ELSU_LO_BIT]   = elsu;
    r[`IE_EBRK_BIT]      = w[`IE_EBRK_BIT];
    r[`IE_EILL_BIT]      = w[`IE_EILL_BIT];
    return r;
  endfunction

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                            input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED @ %0t: %s got 0x%08h exp 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_settings(input dbg_settings_t got, input dbg_settings_t exp,
                                input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED @ %0t: %s got %b exp %b", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("CHECK FAILED @ %0t: %s got %b exp %b", $time, what, got, exp);
    end
  endtask

  task automatic wait_rvalid(input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!debug_rvalid_o && n < RVALID_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!debug_rvalid_o) begin
      err_cnt++;
      $display("no rvalid for the %s request after %0d cycles", what, RVALID_LIMIT);
    end
  endtask

  task automatic wait_halted();
    int n;
    n = 0;
    while (!debug_halted_o && n < HALT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!debug_halted_o) begin
      err_cnt++;
      $display("core did not reach the halted state within %0d cycles", HALT_LIMIT);
    end
  endtask

  //--------------------------------------------------------------------------
  // bus access, one request cycle then wait for rvalid
  //--------------------------------------------------------------------------
  task automatic bus_write(input logic [`DBG_ADDR_W-1:0] addr, input logic [31:0] data);
    @(posedge clk);
    #2;
    debug_req_i   = 1'b1;
    debug_we_i    = 1'b1;
    debug_addr_i  = addr;
    debug_wdata_i = data;
    @(negedge clk);
    check_bit(debug_gnt_o, 1'b1, "write grant");
    @(posedge clk);
    #2;
    debug_req_i = 1'b0;
    debug_we_i  = 1'b0;
    wait_rvalid("write");
  endtask

  task automatic bus_read(input logic [`DBG_ADDR_W-1:0] addr, output logic [31:0] data);
    @(posedge clk);
    #2;
    debug_req_i  = 1'b1;
    debug_we_i   = 1'b0;
    debug_addr_i = addr;
    @(negedge clk);
    check_bit(debug_gnt_o, 1'b1, "read grant");
    @(posedge clk);
    #2;
    debug_req_i = 1'b0;
    wait_rvalid("read");
    data = debug_rdata_o;   // sampled with rvalid
  endtask

  //--------------------------------------------------------------------------
  // directed tests
  //--------------------------------------------------------------------------
  task automatic after_reset();
    logic [31:0] rd;
    check_bit(dbg_req_o, 1'b0, "dbg_req_o after reset");
    check_bit(stall_o, 1'b0, "stall_o after reset");
    check_bit(debug_halted_o, 1'b0, "debug_halted_o after reset");
    check_bit(debug_rvalid_o, 1'b0, "rvalid after reset");
    check_bit(regfile_rreq_o, 1'b0, "rreq after reset");
    check_bit(regfile_wreq_o, 1'b0, "wreq after reset");
    check_bit(jump_req_o, 1'b0, "jump after reset");
    check_settings(settings_o, '0, "settings after reset");
    bus_read(dbg_addr(`REGION_DBGA, `REG_CAUSE), rd);
    check_word(rd, 32'h0000_001F, "CAUSE after reset");
  endtask

  task automatic halt_by_bus();
    logic [31:0] rd;
    bus_write(dbg_addr(`REGION_DBGA, `REG_CTRL), 32'h1 << `CTRL_HALT_BIT);
    check_bit(dbg_req_o, 1'b1, "dbg_req_o held until ack");
    check_bit(stall_o, 1'b0, "no stall before ack");
    wait_halted();
    check_bit(stall_o, 1'b1, "stall_o when halted");
    check_bit(dbg_req_o, 1'b0, "dbg_req_o dropped after ack");
    bus_read(dbg_addr(`REGION_DBGA, `REG_CTRL), rd);
    check_word(rd, 32'h0001_0000, "CTRL after bus halt");
    bus_read(dbg_addr(`REGION_DBGA, `REG_CAUSE), rd);
    check_word(rd, 32'h0000_001F, "CAUSE after bus halt");
  endtask

  task automatic trap_single_step();
    logic [31:0]   rnd, rd;
    logic [5:0]    cause;
    dbg_settings_t exp;
    rand_bits(`CAUSE_W, rnd);
    cause = rnd[5:0];
    bus_write(dbg_addr(`REGION_DBGA, `REG_CTRL), 32'h1);   // resume, sste on
    check_bit(debug_halted_o, 1'b0, "running after CTRL resume");
    check_bit(stall_o, 1'b0, "no stall after CTRL resume");
    @(posedge clk);
    #2;
    sleeping_i  = 1'b1;
    trap_i      = 1'b1;
    exc_cause_i = cause;
    @(negedge clk);
    check_bit(dbg_req_o, 1'b1, "dbg_req_o in trap cycle");
    @(posedge clk);
    #2 trap_i = 1'b0;
    wait_halted();
    bus_read(dbg_addr(`REGION_DBGA, `REG_HIT), rd);
    check_word(rd, 32'h0001_0001, "HIT after single step trap");
    bus_read(dbg_addr(`REGION_DBGA, `REG_CAUSE), rd);
    check_word(rd, {cause[5], 26'b0, cause[4:0]}, "CAUSE after trap");
    exp      = '0;
    exp.sste = 1'b1;
    check_settings(settings_o, exp, "settings with sste");
    bus_write(dbg_addr(`REGION_DBGA, `REG_HIT), 32'h1);   // clear the hit
    bus_read(dbg_addr(`REGION_DBGA, `REG_HIT), rd);
    check_word(rd, 32'h0001_0000, "HIT after clear");
    @(posedge clk);
    #2 sleeping_i = 1'b0;
  endtask

  task automatic ie_settings();
    logic [31:0]   w, rd;
    dbg_settings_t exp;
    for (int k = 0; k < 4; k++) begin
      rand_bits(32, w);
      bus_write(dbg_addr(`REGION_DBGA, `REG_IE), w);
      bus_read(dbg_addr(`REGION_DBGA, `REG_IE), rd);
      check_word(rd, ie_readback(w), "IE readback");
      exp.ecall = w[`IE_ECALL_BIT];
      exp.elsu  = w[`IE_ELSU_HI_BIT] | w[`IE_ELSU_LO_BIT];
      exp.ebrk  = w[`IE_EBRK_BIT];
      exp.eill  = w[`IE_EILL_BIT];
      exp.sste  = 1'b1;   // still set from the trap test
      check_settings(settings_o, exp, "settings after IE write");
    end
  endtask

  task automatic gpr_gating();
    logic [31:0] rnd, data, rd;
    logic [4:0]  idx;
    int          wr_before;
    rand_bits(`REG_ADDR_W, rnd);
    idx = rnd[4:0];
    rand_bits(32, data);
    // halted, access goes through
    wr_before = wr_cnt;
    bus_write(dbg_addr(`REGION_GPR, idx), data);
    check_bit(wr_cnt == wr_before + 1, 1'b1, "one regfile write while halted");
    check_word({27'b0, last_waddr}, {27'b0, idx}, "regfile write index");
    check_word(last_wdata, data, "regfile write data");
    bus_read(dbg_addr(`REGION_GPR, idx), rd);
    check_bit(regfile_rreq_o, 1'b1, "rreq with rvalid");
    check_word(rd, data, "GPR read after write");
    bus_read(dbg_addr(`REGION_GPR, idx ^ 5'h10), rd);
    check_word(rd, fill_word(idx ^ 5'h10), "GPR read of untouched entry");
    // running, refused but granted
    bus_write(dbg_addr(`REGION_DBGA, `REG_CTRL), 32'h1);
    rand_bits(32, data);
    wr_before = wr_cnt;
    bus_write(dbg_addr(`REGION_GPR, idx), data);
    check_bit(wr_cnt == wr_before, 1'b1, "no regfile write while running");
    bus_read(dbg_addr(`REGION_GPR, idx), rd);
    check_bit(regfile_rreq_o, 1'b0, "no rreq while running");
    check_word(rd, 32'h0, "GPR read while running");
  endtask

  task automatic pc_and_jump();
    logic [31:0] pc_a, pc_b, target, rd;
    rand_bits(32, pc_a);
    rand_bits(32, pc_b);
    @(posedge clk);
    #2;
    pc_if_i      = pc_a;
    pc_id_i      = pc_b;
    debug_halt_i = 1'b1;
    @(posedge clk);
    #2 debug_halt_i = 1'b0;
    wait_halted();
    bus_read(dbg_addr(`REGION_DBGA, `REG_CAUSE), rd);
    check_word(rd, 32'h0000_001F, "CAUSE after debug_halt_i");
    bus_read(dbg_addr(`REGION_DBGS, 5'd0), rd);
    check_word(rd, pc_a, "NPC read");
    bus_read(dbg_addr(`REGION_DBGS, 5'd1), rd);
    check_word(rd, pc_b, "PPC read");
    rand_bits(32, target);
    bus_write(dbg_addr(`REGION_DBGS, `REG_NPC), target);
    check_bit(jump_req_o, 1'b1, "jump_req_o after DNPC write");
    check_word(jump_addr_o, target, "jump address");
    @(negedge clk);
    check_bit(jump_req_o, 1'b0, "jump_req_o single cycle");
    @(posedge clk);
    #2 debug_resume_i = 1'b1;
    @(negedge clk);
    check_bit(stall_o, 1'b0, "stall_o drops with resume");
    check_bit(debug_halted_o, 1'b1, "halted still up in resume cycle");
    @(posedge clk);
    #2 debug_resume_i = 1'b0;
    @(negedge clk);
    check_bit(debug_halted_o, 1'b0, "halted drops after resume");
    bus_read(dbg_addr(`REGION_DBGA, `REG_CTRL), rd);
    check_word(rd, 32'h0000_0001, "CTRL after resume");
    bus_read(dbg_addr(`REGION_DBGS, 5'd0), rd);
    check_word(rd, 32'h0, "NPC read while running");
  endtask

  //--------------------------------------------------------------------------
  // main sequence
  //--------------------------------------------------------------------------
  initial begin
    rst_n          = 1'b0;
    debug_req_i    = 1'b0;
    debug_we_i     = 1'b0;
    debug_addr_i   = '0;
    debug_wdata_i  = '0;
    debug_halt_i   = 1'b0;
    debug_resume_i = 1'b0;
    trap_i         = 1'b0;
    exc_cause_i    = '0;
    sleeping_i     = 1'b0;
    pc_if_i        = '0;
    pc_id_i        = '0;
    repeat (2) @(posedge clk);
    #2 rst_n = 1'b1;
    @(negedge clk);

    after_reset();
    halt_by_bus();
    trap_single_step();
    ie_settings();
    gpr_gating();
    pc_and_jump();

    $display("checks: %0d  errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== dbg_unit.f ====
+incdir+hdl
hdl/dbg_pkg.sv
hdl/dbg_halt_if.sv
hdl/dbg_access_if.sv
hdl/dbg_bus_decoder.sv
hdl/dbg_regs.sv
hdl/dbg_halt_ctrl.sv
hdl/dbg_unit_top.sv
bench/dbg_unit_sva.sv
bench/dbg_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the debug unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
  -f dbg_unit.f \
  --top-module dbg_unit_tb \
  -Mdir obj_dir \
  -o sim_dbg_unit

# a failing assertion stops the simulator, so the search below decides
out=$(./obj_dir/sim_dbg_unit 2>&1) || true
echo "$out"

if grep -q "SIMULATION PASSED" <<< "$out"; then
  exit 0
else
  exit 1
fi
